// ==== common/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch address and instruction word
`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32

// address split: tag | index | offset
`define ICACHE_TAG_W       20
`define ICACHE_INDEX_W     8
`define ICACHE_OFFSET_W    4

// geometry
`define ICACHE_SETS        256
`define ICACHE_LINE_WORDS  4   // 16-byte line, four bus beats
`define ICACHE_WAYS        2

`endif

// ==== common/icache_pkg.sv ====
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]                     addr_t;
    typedef logic [`ICACHE_TAG_W-1:0]                      tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]                    index_t;
    typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0]         word_sel_t;
    typedef logic [`ICACHE_WORD_W-1:0]                     word_t;
    typedef logic [`ICACHE_LINE_WORDS*`ICACHE_WORD_W-1:0]  line_t;  // word 0 in low bits

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,
        ST_REFILL,
        ST_REPLY
    } icache_state_t;

    // cpu fetch side
    typedef struct packed {
        logic  valid;   // held until addr_ok
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
        logic  miss;    // word came from a refill
    } fetch_resp_t;

    // read-burst bus
    typedef struct packed {
        logic  rd_req;
        addr_t rd_addr;
    } bus_req_t;

    typedef struct packed {
        logic  rd_rdy;
        logic  ret_valid;
        logic  ret_last;
        word_t ret_data;
    } bus_ret_t;

    typedef struct packed {
        logic unbusy;
        logic last_hit;
    } icache_status_t;

endpackage

`default_nettype wire

// ==== icache/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
(
    input  logic clk,
    input  logic hit_success,
    input  logic req_valid,
    input  logic hit,
    input  logic rd_rdy,
    input  logic line_done,
    output logic addr_ok,
    output logic lookup,
    output logic refill_active,
    output logic fill_we,
    output logic reply_hit,
    output logic reply_miss,
    output logic rd_req,
    output logic unbusy,
    output logic last_hit
);

    icache_state_t state, state_nxt;

    always_ff @(posedge clk or posedge hit_success) begin
        if (hit_success) begin
            state    <= ST_IDLE;
            last_hit <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_LOOKUP)
                last_hit <= hit;  // result of the lookup just finished
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (req_valid) state_nxt = ST_LOOKUP;
            ST_LOOKUP: state_nxt = hit ? ST_IDLE : ST_MISS;
            ST_MISS:   if (rd_rdy) state_nxt = ST_REFILL;
            ST_REFILL: if (line_done) state_nxt = ST_REPLY;  // fill edge
            ST_REPLY:  state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    // front side stalls everywhere but idle
    assign addr_ok       = (state == ST_IDLE);
    assign unbusy        = (state == ST_IDLE);
    assign lookup        = (state == ST_IDLE) && req_valid;
    assign reply_hit     = (state == ST_LOOKUP) && hit;
    assign reply_miss    = (state == ST_REPLY);
    assign rd_req        = (state == ST_MISS);    // level until rd_rdy
    assign refill_active = (state == ST_REFILL);
    assign fill_we       = (state == ST_REFILL) && line_done;

endmodule

`default_nettype wire

// ==== icache/icache_beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_beat_counter
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      hit_success,
    input  logic      refill_active,
    input  logic      ret_valid,
    input  logic      ret_last,
    output word_sel_t beat_idx,
    output logic      line_done
);

    word_sel_t beat_cnt;
    logic      last_slot;

    // count starts over for every refill
    always_ff @(posedge clk or posedge hit_success) begin
        if (hit_success) begin
            beat_cnt <= '0;
        end else if (!refill_active) begin
            beat_cnt <= '0;
        end else if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // current beat lands in this word of the line
    assign beat_idx = beat_cnt;

    assign last_slot = (beat_cnt == word_sel_t'(`ICACHE_LINE_WORDS - 1));

    // ret_last on an early beat is ignored
    assign line_done = refill_active && ret_valid && ret_last && last_slot;

endmodule

`default_nettype wire

// ==== icache/icache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_tag_array
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   hit_success,
    input  logic   rd_en,
    input  logic   fill_we,
    input  index_t rd_index,
    input  index_t fill_index,
    input  tag_t   req_tag,
    output logic   hit,
    output logic   hit_way,
    output logic   victim_way
);

    tag_t                                     tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    tag_t                                     rd_tag [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_bits;
    logic [`ICACHE_SETS-1:0]                  repl_bits;   // victim way per set
    logic [`ICACHE_WAYS-1:0]                  rd_valid;
    logic [`ICACHE_WAYS-1:0]                  way_hit;
    logic                                     lookup_q;    // read data is current

    // tag storage
    always_ff @(posedge clk) begin
        if (fill_we)
            tag_mem[victim_way][fill_index] <= req_tag;
        if (rd_en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++)
                rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    always_ff @(posedge clk or posedge hit_success) begin
        if (hit_success) begin
            valid_bits <= '0;
            repl_bits  <= '0;
            rd_valid   <= '0;
            lookup_q   <= 1'b0;
        end else begin
            lookup_q <= rd_en;
            if (rd_en) begin
                for (int w = 0; w < `ICACHE_WAYS; w++)
                    rd_valid[w] <= valid_bits[w][rd_index];
            end
            if (fill_we) begin
                valid_bits[victim_way][fill_index] <= 1'b1;
                repl_bits[fill_index]              <= ~victim_way;
            end else if (hit) begin
                repl_bits[fill_index] <= ~hit_way;  // keep the line just used
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++)
            way_hit[w] = rd_valid[w] && (rd_tag[w] == req_tag);
    end

    assign hit        = lookup_q && (|way_hit);
    assign hit_way    = ~way_hit[0];  // way 0 wins a double hit
    // fill_index is the registered request index
    assign victim_way = repl_bits[fill_index];

endmodule

`default_nettype wire

// ==== icache/icache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_data_array
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      beat_we,
    input  logic      fill_we,
    input  logic      hit_way,
    input  logic      victim_way,
    input  logic      rd_en,
    input  index_t    rd_index,
    input  index_t    fill_index,
    input  word_sel_t beat_idx,
    input  word_sel_t word_sel,
    input  word_t     ret_data,
    output word_t     hit_word,
    output word_t     fill_word
);

    line_t data_mem [`ICACHE_WAYS][`ICACHE_SETS];
    line_t rd_line [`ICACHE_WAYS];
    line_t line_buf;   // beats collected so far
    line_t fill_line;

    // last beat is merged in on the fill edge itself
    always_comb begin
        fill_line = line_buf;
        fill_line[beat_idx*`ICACHE_WORD_W +: `ICACHE_WORD_W] = ret_data;
    end

    always_ff @(posedge clk) begin
        if (beat_we)
            line_buf[beat_idx*`ICACHE_WORD_W +: `ICACHE_WORD_W] <= ret_data;
        if (fill_we)
            data_mem[victim_way][fill_index] <= fill_line;
        if (rd_en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++)
                rd_line[w] <= data_mem[w][rd_index];
        end
    end

    assign hit_word  = rd_line[hit_way][word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];
    assign fill_word = line_buf[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];  // valid in reply

endmodule

`default_nettype wire

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic           clk,
    input  logic           hit_success,
    input  fetch_req_t     fetch_req,
    output fetch_resp_t    fetch_resp,
    output bus_req_t       bus_req,
    input  bus_ret_t       bus_ret,
    output icache_status_t status
);

    addr_t     req_addr;
    tag_t      req_tag;
    index_t    req_index;
    index_t    fetch_index;
    word_sel_t req_word;
    word_sel_t beat_idx;
    word_t     hit_word;
    word_t     fill_word;
    logic      addr_ok, lookup, refill_active, fill_we, reply_hit, reply_miss;
    logic      rd_req, unbusy, last_hit;
    logic      hit, hit_way, victim_way, line_done, beat_we;

    // accepted fetch address
    always_ff @(posedge clk) begin
        if (lookup)
            req_addr <= fetch_req.addr;
    end

    assign req_tag     = req_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign req_index   = req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign req_word    = req_addr[`ICACHE_OFFSET_W-1 -: $bits(word_sel_t)];
    assign fetch_index = fetch_req.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];  // arrays read at accept
    assign beat_we     = refill_active && bus_ret.ret_valid;

    icache_ctrl u_ctrl (
        .clk(clk), .hit_success(hit_success), .req_valid(fetch_req.valid), .hit(hit),
        .rd_rdy(bus_ret.rd_rdy), .line_done(line_done), .addr_ok(addr_ok), .lookup(lookup),
        .refill_active(refill_active), .fill_we(fill_we), .reply_hit(reply_hit),
        .reply_miss(reply_miss), .rd_req(rd_req), .unbusy(unbusy), .last_hit(last_hit)
    );

    icache_beat_counter u_beat_counter (
        .clk(clk), .hit_success(hit_success), .refill_active(refill_active),
        .ret_valid(bus_ret.ret_valid), .ret_last(bus_ret.ret_last),
        .beat_idx(beat_idx), .line_done(line_done)
    );

    icache_tag_array u_tag_array (
        .clk(clk), .hit_success(hit_success), .rd_en(lookup), .fill_we(fill_we),
        .rd_index(fetch_index), .fill_index(req_index), .req_tag(req_tag),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way)
    );

    icache_data_array u_data_array (
        .clk(clk), .beat_we(beat_we), .fill_we(fill_we), .hit_way(hit_way),
        .victim_way(victim_way), .rd_en(lookup), .rd_index(fetch_index),
        .fill_index(req_index), .beat_idx(beat_idx), .word_sel(req_word),
        .ret_data(bus_ret.ret_data), .hit_word(hit_word), .fill_word(fill_word)
    );

    always_comb begin
        fetch_resp.addr_ok = addr_ok;
        fetch_resp.data_ok = reply_hit || reply_miss;
        fetch_resp.rdata   = reply_miss ? fill_word : hit_word;
        fetch_resp.miss    = reply_miss;
        bus_req.rd_req     = rd_req;
        bus_req.rd_addr    = {req_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
        status.unbusy      = unbusy;
        status.last_hit    = last_hit;
    end

endmodule

`default_nettype wire

// ==== verif/icache_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_assert
    import icache_pkg::*;
(
    input logic           clk,
    input logic           hit_success,
    input fetch_req_t     fetch_req,
    input fetch_resp_t    fetch_resp,
    input bus_req_t       bus_req,
    input bus_ret_t       bus_ret,
    input icache_status_t status
);

    logic pending;  // accepted fetch still owes a reply

    always_ff @(posedge clk or posedge hit_success) begin
        if (hit_success)
            pending <= 1'b0;
        else if (fetch_req.valid && fetch_resp.addr_ok)
            pending <= 1'b1;
        else if (fetch_resp.data_ok)
            pending <= 1'b0;
    end

    // front port stays closed while a fetch is outstanding
    a_addr_ok_idle: assert property (@(posedge clk) disable iff (hit_success)
        fetch_resp.addr_ok |-> status.unbusy && !pending)
        else $error("addr_ok high while the cache is busy");

    a_data_ok_pulse: assert property (@(posedge clk) disable iff (hit_success)
        fetch_resp.data_ok |=> !fetch_resp.data_ok)
        else $error("data_ok held longer than one cycle");

    // level request until the memory takes it
    a_rd_req_held: assert property (@(posedge clk) disable iff (hit_success)
        bus_req.rd_req && !bus_ret.rd_rdy |=> bus_req.rd_req)
        else $error("rd_req dropped before rd_rdy");

    a_data_ok_req: assert property (@(posedge clk) disable iff (hit_success)
        fetch_resp.data_ok |-> pending)
        else $error("data_ok without an accepted fetch");

endmodule

bind icache_top icache_assert u_assert (
    .clk(clk), .hit_success(hit_success), .fetch_req(fetch_req), .fetch_resp(fetch_resp),
    .bus_req(bus_req), .bus_ret(bus_ret), .status(status)
);

`default_nettype wire

// ==== verif/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int    CLK_PERIOD    = 20;
    localparam int    NUM_FETCHES   = 400;
    localparam int    MAX_RDY_DELAY = 6;
    localparam int    MAX_BEAT_GAP  = 3;
    localparam int    MAX_FETCH_CYC = MAX_RDY_DELAY + 4 * (MAX_BEAT_GAP + 1) + 6;
    localparam word_t MEM_MULT      = 32'h9e37_79b1;  // odd multiplier

    logic                    clk;
    logic                    hit_success;
    fetch_req_t              fetch_req;
    fetch_resp_t             fetch_resp;
    bus_req_t                bus_req;
    bus_ret_t                bus_ret;
    icache_status_t          status;
    tag_t                    model_tag [2][`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] model_valid [2];
    logic [`ICACHE_SETS-1:0] model_repl;      // victim way per set
    tag_t                    tag_pool [6];
    index_t                  index_pool [4];  // small pool so lines get evicted

    icache_top u_dut (
        .clk(clk), .hit_success(hit_success), .fetch_req(fetch_req),
        .fetch_resp(fetch_resp), .bus_req(bus_req), .bus_ret(bus_ret), .status(status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // memory contents by word address
    function automatic word_t mem_word(input addr_t a);
        return {a[31:2], 2'b00} * MEM_MULT;
    endfunction

    // returns the predicted hit and updates tags and replacement bits
    function automatic logic model_access(input tag_t t, input index_t i);
        logic v;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][i] && model_tag[w][i] == t) begin
                model_repl[i] = (w == 0);  // other way becomes the victim
                return 1'b1;
            end
        end
        v = model_repl[i];
        model_tag[v][i]   = t;
        model_valid[v][i] = 1'b1;
        model_repl[i]     = ~v;
        return 1'b0;
    endfunction

    // one fetch from an idle cache with the memory side played on a miss
    task automatic do_fetch(input tag_t t, input index_t i, input word_sel_t ws,
                            output logic dut_hit);
        addr_t a;
        logic  exp_hit;
        a       = {t, i, ws, 2'b00};
        exp_hit = model_access(t, i);
        check_flag("fetch_resp.addr_ok", fetch_resp.addr_ok, 1'b1);
        fetch_req.valid = 1'b1;
        fetch_req.addr  = a;
        @(negedge clk);  // accepted at the edge just passed
        fetch_req.valid = 1'b0;
        dut_hit = fetch_resp.data_ok;
        check_flag("fetch_resp.data_ok", fetch_resp.data_ok, exp_hit);
        check_flag("bus_req.rd_req", bus_req.rd_req, 1'b0);
        check_flag("fetch_resp.addr_ok", fetch_resp.addr_ok, 1'b0);
        check_flag("status.unbusy", status.unbusy, 1'b0);
        if (!exp_hit) begin
            while (!bus_req.rd_req)
                @(negedge clk);
            check_addr("bus_req.rd_addr", bus_req.rd_addr, {a[31:4], 4'h0});
            repeat ($urandom_range(MAX_RDY_DELAY))
                @(negedge clk);
            bus_ret.rd_rdy = 1'b1;
            @(negedge clk);
            bus_ret.rd_rdy = 1'b0;
            for (int b = 0; b < `ICACHE_LINE_WORDS; b++) begin
                repeat ($urandom_range(MAX_BEAT_GAP))
                    @(negedge clk);
                bus_ret.ret_valid = 1'b1;
                bus_ret.ret_last  = (b == `ICACHE_LINE_WORDS - 1);
                bus_ret.ret_data  = mem_word({a[31:4], 4'h0} + addr_t'(4 * b));
                @(negedge clk);
                bus_ret.ret_valid = 1'b0;
                bus_ret.ret_last  = 1'b0;
            end
            while (!fetch_resp.data_ok)
                @(negedge clk);
        end
        check_flag("fetch_resp.miss", fetch_resp.miss, !exp_hit);
        check_word("fetch_resp.rdata", fetch_resp.rdata, mem_word(a));
        @(negedge clk);
        check_flag("status.last_hit", status.last_hit, exp_hit);
        check_flag("status.unbusy", status.unbusy, 1'b1);
    endtask

    initial begin
        logic h;
        void'($urandom(32'h9075_fabe));
        hit_success    = 1'b1;
        fetch_req      = '0;
        bus_ret        = '0;
        model_valid[0] = '0;
        model_valid[1] = '0;
        model_repl     = '0;
        foreach (tag_pool[k])
            tag_pool[k] = tag_t'($urandom);
        foreach (index_pool[k])
            index_pool[k] = index_t'($urandom);
        repeat (4) @(posedge clk);
        @(negedge clk);
        hit_success = 1'b0;
        check_flag("fetch_resp.addr_ok", fetch_resp.addr_ok, 1'b1);
        check_flag("bus_req.rd_req", bus_req.rd_req, 1'b0);
        check_flag("fetch_resp.data_ok", fetch_resp.data_ok, 1'b0);
        check_flag("status.unbusy", status.unbusy, 1'b1);
        check_flag("status.last_hit", status.last_hit, 1'b0);

        // fill both ways of set c3 and then add a third tag
        do_fetch(20'h1_1111, 8'hc3, 2'd0, h);
        do_fetch(20'h2_2222, 8'hc3, 2'd1, h);
        do_fetch(20'h3_3333, 8'hc3, 2'd2, h);  // way 0 is the victim
        do_fetch(20'h2_2222, 8'hc3, 2'd3, h);
        check_flag("kept line hit", h, 1'b1);
        do_fetch(20'h1_1111, 8'hc3, 2'd0, h);
        check_flag("evicted line hit", h, 1'b0);

        for (int n = 0; n < NUM_FETCHES; n++)
            do_fetch(tag_pool[$urandom_range(5)], index_pool[$urandom_range(3)],
                     word_sel_t'($urandom), h);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // every fetch at its longest refill plus reset and margin
    initial begin
        #(CLK_PERIOD * ((NUM_FETCHES + 10) * MAX_FETCH_CYC + 20));
        fail_run("timeout before all fetches completed");
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/icache_pkg.sv
icache/icache_ctrl.sv
icache/icache_beat_counter.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
rtl/icache_top.sv
verif/icache_assert.sv
verif/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the icache testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module icache_tb -Mdir obj_dir -f build.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vicache_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
